// File: design/sys_bus_pkg.sv
package sys_bus_pkg;

	// Bus widths shared by every master port and the RAM
	localparam int ADDR_W = 32;	// Byte address
	localparam int DATA_W = 32;	// One word per transfer

	// Command latched from the client and driven as m_rd or m_wr
	typedef enum logic
	{
		OP_READ  = 1'b0,	// Load one word
		OP_WRITE = 1'b1	// Store one word
	} bus_op_t;

	// Master port FSM
	typedef enum logic [1:0]
	{
		ST_IDLE     = 2'd0,	// Free, client may strobe
		ST_REQUEST  = 2'd1,	// bus_req up, waiting for grant
		ST_TRANSFER = 2'd2	// Granted, waiting for bus_ready
	} master_state_t;

endpackage

// File: design/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
#(
	parameter int NUM_MASTERS = 4	// Number of requesters
)
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [NUM_MASTERS-1:0] bus_req,	// One bit per master port
	input  logic                   bus_ready,	// End of the current transfer
	output logic [NUM_MASTERS-1:0] grant	// One-hot or zero, registered
);

	logic [NUM_MASTERS-1:0] grant_q;	// Current owner of the bus
	logic [NUM_MASTERS-1:0] pick;	// Lowest-index requester
	logic                   hold_q;	// Grant is locked until ready
	logic                   any_req;	// Someone wants the bus

	assign any_req = |bus_req;

	// Fixed priority, index 0 wins
	always_comb
	begin
		pick = '0;
		for (int i = NUM_MASTERS - 1; i >= 0; i--)	// Walk down so lowest hit stays
		begin
			if (bus_req[i])
			begin
				pick    = '0;	// Drop any higher-index hit
				pick[i] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			grant_q <= '0;
			hold_q  <= 1'b0;
		end
		else if (hold_q)
		begin
			if (bus_ready)	// Transfer done, release next cycle
			begin
				grant_q <= '0;
				hold_q  <= 1'b0;
			end
		end
		else if (any_req)	// Bus free and someone waiting
		begin
			grant_q <= pick;
			hold_q  <= 1'b1;	// Lock out late higher-priority arrivals
		end
	end

	// A free cycle always follows the release, so the RAM sees the
	// command drop before the next owner drives its lines
	assign grant = grant_q;

endmodule

// File: design/bus_master_port.sv
`timescale 1ns/1ps

module bus_master_port
(
	input  logic                          clk,
	input  logic                          rst,
	// Client side
	input  logic                          req_valid,	// One-cycle strobe
	input  logic                          req_write,	// 1 for store
	input  logic [sys_bus_pkg::ADDR_W-1:0] req_addr,	// Byte address
	input  logic [sys_bus_pkg::DATA_W-1:0] req_wdata,	// Store data
	output logic                          busy,	// Request in flight
	output logic                          rsp_valid,	// One-cycle completion strobe
	output logic [sys_bus_pkg::DATA_W-1:0] rsp_rdata,	// Load data, zero for stores
	// Bus side
	input  logic                          grant,	// From arbiter
	input  logic [sys_bus_pkg::DATA_W-1:0] bus_rdata,	// OR-merged responder data
	input  logic                          bus_ready,	// Transfer done pulse
	output logic                          bus_req,	// To arbiter
	output logic [sys_bus_pkg::ADDR_W-1:0] m_addr,	// Zero unless granted
	output logic [sys_bus_pkg::DATA_W-1:0] m_wdata,	// Zero unless granted
	output logic                          m_rd,
	output logic                          m_wr
);

	import sys_bus_pkg::*;

	master_state_t     state_q;	// Port FSM
	master_state_t     state_d;
	bus_op_t           op_q;	// Latched command
	logic [ADDR_W-1:0] addr_q;	// Latched address
	logic [DATA_W-1:0] wdata_q;	// Latched store data
	logic [DATA_W-1:0] rdata_q;	// Response data
	logic              rsp_q;	// Response strobe
	logic              owner;	// We hold the bus right now
	logic              accept;	// Client strobe taken
	logic              done;	// Our transfer finished this cycle

	assign accept = req_valid && (state_q == ST_IDLE);
	assign owner  = grant && (state_q != ST_IDLE);
	assign done   = owner && bus_ready && (state_q == ST_TRANSFER);

	// Next state
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
			begin
				if (accept)
					state_d = ST_REQUEST;
			end
			ST_REQUEST:
			begin
				if (grant)	// Lines already out this cycle
					state_d = ST_TRANSFER;
			end
			ST_TRANSFER:
			begin
				if (done)	// Back to idle, busy drops with rsp_valid
					state_d = ST_IDLE;
			end
			default:
				state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= ST_IDLE;
			rsp_q   <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			rsp_q   <= done;	// One pulse per request
		end
	end

	// Request payload, taken only on a client strobe
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			op_q    <= req_write ? OP_WRITE : OP_READ;
			addr_q  <= req_addr;
			wdata_q <= req_wdata;
		end
	end

	// Response payload
	always_ff @(posedge clk)
	begin
		if (done)
			rdata_q <= (op_q == OP_READ) ? bus_rdata : '0;	// Stores answer zero
	end

	assign busy      = (state_q != ST_IDLE);
	assign rsp_valid = rsp_q;
	assign rsp_rdata = rdata_q;
	assign bus_req   = (state_q != ST_IDLE);	// Held through the transfer

	// Gated lines so the responder can OR every master together
	assign m_addr  = owner ? addr_q : '0;
	assign m_wdata = (owner && op_q == OP_WRITE) ? wdata_q : '0;
	assign m_rd    = owner && (op_q == OP_READ);
	assign m_wr    = owner && (op_q == OP_WRITE);

endmodule

// File: design/bus_block_ram.sv
`timescale 1ns/1ps

module bus_block_ram
#(
	parameter int NUM_MASTERS = 4,	// Slices to merge
	parameter int RAM_ADDR_W  = 8,	// log2 of depth in words
	parameter int RAM_WAIT    = 2	// Cycles before bus_ready
)
(
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic [NUM_MASTERS-1:0][sys_bus_pkg::ADDR_W-1:0] m_addr,	// Per-master slices
	input  logic [NUM_MASTERS-1:0][sys_bus_pkg::DATA_W-1:0] m_wdata,
	input  logic [NUM_MASTERS-1:0]                          m_rd,
	input  logic [NUM_MASTERS-1:0]                          m_wr,
	output logic [sys_bus_pkg::DATA_W-1:0]                  bus_rdata,	// Valid in ready cycle only
	output logic                                           bus_ready	// One-cycle pulse
);

	import sys_bus_pkg::*;

	localparam int RAM_DEPTH = 1 << RAM_ADDR_W;
	localparam int CNT_W     = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;
	localparam logic [CNT_W-1:0] WAIT_CNT = CNT_W'(RAM_WAIT);

	logic [DATA_W-1:0]     mem [0:RAM_DEPTH-1];	// Word storage
	logic [ADDR_W-1:0]     addr_or;	// Merged address
	logic [DATA_W-1:0]     wdata_or;	// Merged store data
	logic                  rd_or;
	logic                  wr_or;
	logic                  cmd_valid;	// Some master is driving
	bus_op_t               cmd_op;
	logic [RAM_ADDR_W-1:0] word_idx;	// Byte address to word
	logic [CNT_W-1:0]      cnt_q;	// Wait counter
	logic                  done_q;	// Answered, waiting for cmd to drop
	logic                  ready_q;
	logic [DATA_W-1:0]     rdata_q;
	logic                  fire;	// Serve the command this edge

	// Only the granted master drives nonzero lines
	always_comb
	begin
		addr_or  = '0;
		wdata_or = '0;
		for (int i = 0; i < NUM_MASTERS; i++)
		begin
			addr_or  = addr_or | m_addr[i];
			wdata_or = wdata_or | m_wdata[i];
		end
	end

	assign rd_or     = |m_rd;
	assign wr_or     = |m_wr;
	assign cmd_valid = rd_or | wr_or;
	assign cmd_op    = wr_or ? OP_WRITE : OP_READ;
	assign word_idx  = addr_or[RAM_ADDR_W+1:2];	// Upper bits ignored
	assign fire      = cmd_valid && !done_q && (cnt_q == WAIT_CNT);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			cnt_q   <= '0;
			done_q  <= 1'b0;
			ready_q <= 1'b0;
		end
		else
		begin
			ready_q <= fire;
			if (!cmd_valid)	// Rearm once the owner lets go
			begin
				cnt_q  <= '0;
				done_q <= 1'b0;
			end
			else if (fire)
				done_q <= 1'b1;
			else if (!done_q)
				cnt_q <= cnt_q + CNT_W'(1);
		end
	end

	// Array access on the edge that raises bus_ready
	always_ff @(posedge clk)
	begin
		if (fire)
		begin
			if (cmd_op == OP_WRITE)
			begin
				mem[word_idx] <= wdata_or;
				rdata_q       <= '0;
			end
			else
				rdata_q <= mem[word_idx];
		end
	end

	assign bus_ready = ready_q;
	assign bus_rdata = ready_q ? rdata_q : '0;	// Keep the merged data bus clean

endmodule

// File: design/sys_bus_top.sv
`timescale 1ns/1ps

module sys_bus_top
#(
	parameter int NUM_MASTERS = 4,	// Client ports
	parameter int RAM_ADDR_W  = 8,	// 256 words
	parameter int RAM_WAIT    = 2	// RAM latency in cycles
)
(
	input  logic                                           clk,
	input  logic                                           rst,
	input  logic [NUM_MASTERS-1:0]                          req_valid,	// Per-port strobe
	input  logic [NUM_MASTERS-1:0]                          req_write,
	input  logic [NUM_MASTERS-1:0][sys_bus_pkg::ADDR_W-1:0] req_addr,
	input  logic [NUM_MASTERS-1:0][sys_bus_pkg::DATA_W-1:0] req_wdata,
	output logic [NUM_MASTERS-1:0]                          busy,
	output logic [NUM_MASTERS-1:0]                          rsp_valid,
	output logic [NUM_MASTERS-1:0][sys_bus_pkg::DATA_W-1:0] rsp_rdata
);

	import sys_bus_pkg::*;

	logic [NUM_MASTERS-1:0]             bus_req;	// Ports to arbiter
	logic [NUM_MASTERS-1:0]             grant;	// Arbiter to ports
	logic [NUM_MASTERS-1:0][ADDR_W-1:0] m_addr;	// Gated master slices
	logic [NUM_MASTERS-1:0][DATA_W-1:0] m_wdata;
	logic [NUM_MASTERS-1:0]             m_rd;
	logic [NUM_MASTERS-1:0]             m_wr;
	logic [DATA_W-1:0]                  bus_rdata;	// RAM to every port
	logic                               bus_ready;

	bus_arbiter
	#(
		.NUM_MASTERS (NUM_MASTERS)
	)
	u_bus_arbiter
	(
		.clk       (clk),
		.rst       (rst),
		.bus_req   (bus_req),
		.bus_ready (bus_ready),
		.grant     (grant)
	);

	// Identical ports, one per client
	for (genvar g = 0; g < NUM_MASTERS; g++)
	begin : g_master
		bus_master_port u_bus_master_port
		(
			.clk       (clk),
			.rst       (rst),
			.req_valid (req_valid[g]),
			.req_write (req_write[g]),
			.req_addr  (req_addr[g]),
			.req_wdata (req_wdata[g]),
			.busy      (busy[g]),
			.rsp_valid (rsp_valid[g]),
			.rsp_rdata (rsp_rdata[g]),
			.grant     (grant[g]),
			.bus_rdata (bus_rdata),
			.bus_ready (bus_ready),
			.bus_req   (bus_req[g]),
			.m_addr    (m_addr[g]),
			.m_wdata   (m_wdata[g]),
			.m_rd      (m_rd[g]),
			.m_wr      (m_wr[g])
		);
	end

	bus_block_ram
	#(
		.NUM_MASTERS (NUM_MASTERS),
		.RAM_ADDR_W  (RAM_ADDR_W),
		.RAM_WAIT    (RAM_WAIT)
	)
	u_bus_block_ram
	(
		.clk       (clk),
		.rst       (rst),
		.m_addr    (m_addr),
		.m_wdata   (m_wdata),
		.m_rd      (m_rd),
		.m_wr      (m_wr),
		.bus_rdata (bus_rdata),
		.bus_ready (bus_ready)
	);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
#(
	parameter int HALF_PERIOD_NS = 10	// 20 ns period
)
(
	output logic clk
);

	initial
		clk = 1'b0;

	always
		#(HALF_PERIOD_NS) clk = ~clk;	// Free-running

endmodule

// File: testbench/sys_bus_assertions.sv
`timescale 1ns/1ps

module sys_bus_assertions
#(
	parameter int NUM_MASTERS = 4
)
(
	input logic                   clk,
	input logic                   rst,
	input logic [NUM_MASTERS-1:0] bus_req,
	input logic [NUM_MASTERS-1:0] grant,
	input logic                   bus_ready,
	input logic [NUM_MASTERS-1:0] busy,
	input logic [NUM_MASTERS-1:0] rsp_valid
);

	int fail_count = 0;	// Failed assertion count

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
	else
	begin
		$error("grant is not one-hot or zero: %b", grant);
		fail_count++;
	end

	// Owner must still be asking for the bus
	a_grant_req: assert property (@(posedge clk) disable iff (rst) (grant & ~bus_req) == '0)
	else
	begin
		$error("grant %b given without bus_req %b", grant, bus_req);
		fail_count++;
	end

	a_ready_pulse: assert property (@(posedge clk) disable iff (rst) bus_ready |=> !bus_ready)
	else
	begin
		$error("bus_ready high for two cycles");
		fail_count++;
	end

	// busy drops on the same edge, so look one cycle back
	a_rsp_busy: assert property (@(posedge clk) disable iff (rst)
		((rsp_valid & ~$past(rsp_valid)) & ~$past(busy)) == '0)
	else
	begin
		$error("rsp_valid %b rose on an idle port", rsp_valid);
		fail_count++;
	end

endmodule

bind sys_bus_top sys_bus_assertions
#(
	.NUM_MASTERS (NUM_MASTERS)
)
u_sys_bus_assertions
(
	.clk       (clk),
	.rst       (rst),
	.bus_req   (bus_req),
	.grant     (grant),
	.bus_ready (bus_ready),
	.busy      (busy),
	.rsp_valid (rsp_valid)
);

// File: testbench/tb_sys_bus.sv
`timescale 1ns/1ps

module tb_sys_bus;

	import sys_bus_pkg::*;

	localparam int NUM_MASTERS     = 4;	// DUT defaults
	localparam int RAM_ADDR_W      = 8;
	localparam int RAM_WAIT        = 2;
	localparam int RESET_CYCLES    = 16;
	localparam int RAND_PER_MASTER = 100;	// Random requests per port
	localparam int IDLE_LATENCY    = RAM_WAIT + 4;	// Strobe to rsp_valid on an idle bus
	localparam int RAM_WORDS       = 1 << RAM_ADDR_W;
	localparam int REGION          = RAM_WORDS / NUM_MASTERS;	// Words owned per master
	localparam int REGION_BITS     = $clog2(REGION);
	localparam int TOTAL_REQ       = 4 + 2 * NUM_MASTERS + NUM_MASTERS * RAND_PER_MASTER;
	localparam int TIMEOUT_CYCLES  = 200 * TOTAL_REQ + RESET_CYCLES;

	logic                               clk;
	logic                               rst;
	logic [NUM_MASTERS-1:0]             req_valid;
	logic [NUM_MASTERS-1:0]             req_write;
	logic [NUM_MASTERS-1:0][ADDR_W-1:0] req_addr;
	logic [NUM_MASTERS-1:0][DATA_W-1:0] req_wdata;
	logic [NUM_MASTERS-1:0]             busy;
	logic [NUM_MASTERS-1:0]             rsp_valid;
	logic [NUM_MASTERS-1:0][DATA_W-1:0] rsp_rdata;

	int          cyc = 0;	// Rising edges so far
	logic [15:0] lfsr_state = 16'd3371;
	logic [DATA_W-1:0] shadow [RAM_WORDS];	// Last written data per word
	bit          written [RAM_WORDS];
	logic [DATA_W-1:0] exp_q [NUM_MASTERS][$];	// Expected rsp_rdata per port
	int          issue_q [NUM_MASTERS][$];	// Strobe cycle per request
	int          issued [NUM_MASTERS];
	int          rsp_count [NUM_MASTERS];
	int          rsp_cyc [NUM_MASTERS];	// Cycle of the latest response
	int          rand_left [NUM_MASTERS];
	bit          check_latency = 1'b0;
	int          data_errs = 0;
	int          timing_errs = 0;
	int          flow_errs = 0;

	tb_clock_gen u_tb_clock_gen
	(
		.clk (clk)
	);

	sys_bus_top u_sys_bus_top
	(
		.clk       (clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.busy      (busy),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata)
	);

	always @(posedge clk)
		cyc <= cyc + 1;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);	// One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Reference model of the response data
	function automatic logic [DATA_W-1:0] expected_rsp(input bit wr, input int word);
		if (wr)
			return '0;	// Stores answer zero
		return shadow[word];
	endfunction

	function automatic int rand_remaining();
		int sum;
		sum = 0;
		for (int m = 0; m < NUM_MASTERS; m++)
			sum += rand_left[m];
		return sum;
	endfunction

	function automatic int error_total();
		return data_errs + timing_errs + flow_errs + u_sys_bus_top.u_sys_bus_assertions.fail_count;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
		req_valid = '0;	// Strobes last one cycle
	endtask

	task automatic start_request(input int m, input bit wr, input int word,
		input logic [DATA_W-1:0] data);
		req_valid[m] = 1'b1;
		req_write[m] = wr;
		req_addr[m]  = ADDR_W'(word * 4);	// Byte address
		req_wdata[m] = data;
		exp_q[m].push_back(expected_rsp(wr, word));
		issue_q[m].push_back(cyc);
		issued[m]++;
		if (wr)
		begin
			shadow[word]  = data;
			written[word] = 1'b1;
		end
	endtask

	task automatic random_request(input int m);
		bit                wr;
		int                word;
		logic [DATA_W-1:0] data;
		wr   = (take_bits(1) != '0);
		word = m * REGION + int'(take_bits(REGION_BITS));	// Own region only
		data = take_bits(DATA_W);
		if (!written[word])
			wr = 1'b1;	// Write first while contents are unknown
		start_request(m, wr, word, data);
		rand_left[m]--;
	endtask

	// Until every port is idle and every response is checked
	task automatic wait_idle();
		bit pending;
		pending = 1'b1;
		while (pending)
		begin
			next_cycle();
			pending = (busy != '0);
			for (int m = 0; m < NUM_MASTERS; m++)
				if (exp_q[m].size() != 0)
					pending = 1'b1;
		end
	endtask

	task automatic check_balance();
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			assert (rsp_count[m] == issued[m])
			else
			begin
				flow_errs++;
				$display("MISMATCH at %0t: master %0d gave %0d responses for %0d requests",
					$time, m, rsp_count[m], issued[m]);
			end
		end
	endtask

	task automatic check_response(input int m);
		logic [DATA_W-1:0] exp_data;
		int                lat;
		rsp_count[m]++;
		rsp_cyc[m] = cyc;
		assert (!busy[m])	// busy drops with rsp_valid
		else
		begin
			flow_errs++;
			$display("MISMATCH at %0t: master %0d busy still high with rsp_valid", $time, m);
		end
		assert (exp_q[m].size() != 0)
		else
		begin
			data_errs++;
			$display("Master %0d gave a response with no request outstanding at %0t", m, $time);
		end
		if (exp_q[m].size() != 0)
		begin
			exp_data = exp_q[m].pop_front();
			lat      = cyc - issue_q[m].pop_front();
			assert (rsp_rdata[m] === exp_data)
			else
			begin
				data_errs++;
				$display("MISMATCH at %0t: master %0d returned %h, expected %h",
					$time, m, rsp_rdata[m], exp_data);
			end
			if (check_latency)
			begin
				assert (lat == IDLE_LATENCY)
				else
				begin
					timing_errs++;
					$display("MISMATCH at %0t: master %0d latency %0d cycles, expected %0d",
						$time, m, lat, IDLE_LATENCY);
				end
			end
		end
	endtask

	task automatic final_report();
		$display("Error counts: data %0d, latency %0d, flow %0d, assertions %0d",
			data_errs, timing_errs, flow_errs, u_sys_bus_top.u_sys_bus_assertions.fail_count);
	endtask

	// Responses are stable mid-cycle
	always @(negedge clk)
	begin
		if (!rst)
			for (int m = 0; m < NUM_MASTERS; m++)
				if (rsp_valid[m])
					check_response(m);
	end

	initial
	begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		final_report();
		$display("Finished with errors");
		$finish;
	end

	initial
	begin
		rst       = 1'b1;
		req_valid = '0;
		req_write = '0;
		req_addr  = '0;
		req_wdata = '0;
		for (int m = 0; m < NUM_MASTERS; m++)
		begin
			issued[m]    = 0;
			rsp_count[m] = 0;
			rsp_cyc[m]   = 0;
			rand_left[m] = RAND_PER_MASTER;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst = 1'b0;

		next_cycle();	// Quiet ports after reset
		assert (busy == '0 && rsp_valid == '0)
		else
		begin
			flow_errs++;
			$display("MISMATCH at %0t: busy %b rsp_valid %b after reset", $time, busy, rsp_valid);
		end

		check_latency = 1'b1;	// Write then read back on an idle bus
		start_request(1, 1'b1, REGION + 5, take_bits(DATA_W));
		wait_idle();
		start_request(1, 1'b0, REGION + 5, '0);
		wait_idle();
		check_latency = 1'b0;

		start_request(2, 1'b1, 2 * REGION + 7, take_bits(DATA_W));	// Same-cycle pair
		start_request(0, 1'b1, 9, take_bits(DATA_W));
		wait_idle();
		assert (rsp_cyc[0] < rsp_cyc[2])
		else
		begin
			flow_errs++;
			$display("Master 0 did not finish before master 2 (cycles %0d and %0d)",
				rsp_cyc[0], rsp_cyc[2]);
		end

		for (int m = 0; m < NUM_MASTERS; m++)	// Everyone at once
			start_request(m, 1'b1, m * REGION + 20, take_bits(DATA_W));
		wait_idle();
		for (int m = 0; m < NUM_MASTERS; m++)
			start_request(m, 1'b0, m * REGION + 20, '0);
		wait_idle();
		check_balance();

		while (rand_remaining() > 0)	// Random traffic whenever a port is free
		begin
			next_cycle();
			for (int m = 0; m < NUM_MASTERS; m++)
			begin
				if (!busy[m] && rand_left[m] > 0)
				begin
					if (take_bits(1) != '0)
						random_request(m);
				end
			end
		end
		wait_idle();
		check_balance();

		final_report();
		if (error_total() == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: all.f
design/sys_bus_pkg.sv
design/bus_arbiter.sv
design/bus_master_port.sv
design/bus_block_ram.sv
design/sys_bus_top.sv
testbench/tb_clock_gen.sv
testbench/sys_bus_assertions.sv
testbench/tb_sys_bus.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_sys_bus -Mdir obj_dir -f all.f
	./obj_dir/Vtb_sys_bus +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Finished with errors" sim.log; then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
